// ==== Bender.yml ====
package:
  name: rom_check

sources:
  - files:
      - hdl/rom_check_pkg.sv
      - hdl/rom_check_reader.sv
      - hdl/rom_check_digest_store.sv
      - hdl/rom_check_compare.sv
      - hdl/rom_check_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rom_check.sv

// ==== hdl/rom_check_compare.sv ====
`timescale 1ns/1ps
// Digest comparator FSM checking each word against the expected digest and flagging inconsistency
module rom_check_compare import rom_check_pkg::*; #(
  parameter int NumWords = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic [NumWords*32-1:0] digest_i,
  input  logic [NumWords*32-1:0] exp_digest_i,
  output logic                   done_o,
  output mubi4_t                 good_o,
  output logic                   alert_o
);

  localparam int              CntW    = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam logic [CntW-1:0] LastCnt = CntW'(NumWords - 1);

  // All-zero code left illegal
  typedef enum logic [1:0] {
    Waiting  = 2'b01,
    Checking = 2'b10,
    Done     = 2'b11
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic [CntW-1:0] cnt_q;
  logic            match_q;
  logic            match_d;
  mubi4_t          good_q;
  mubi4_t          good_d;
  logic            fsm_alert;
  logic            start_alert;
  logic            wait_cnt_alert;
  logic            done_cnt_alert;
  rom_word_data_t  digest_word;
  rom_word_data_t  exp_word;

  // Next state
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      Waiting: begin
        if (start_i) state_d = Checking;
      end
      Checking: begin
        if (cnt_q == LastCnt) state_d = Done;
      end
      Done: begin
        // Final, left only by reset
      end
      default: fsm_alert = 1'b1;
    endcase
  end

  // Word under comparison
  assign digest_word = digest_i[cnt_q * 32 +: 32];
  assign exp_word    = exp_digest_i[cnt_q * 32 +: 32];

  // Any differing word clears the match flag
  assign match_d = (state_q == Checking) ? (match_q && (digest_word == exp_word)) : match_q;

  // Good result computed ahead so it appears together with done
  assign good_d = ((state_d == Done) && match_d) ? MuBi4True : MuBi4False;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Waiting;
      cnt_q   <= '0;
      match_q <= 1'b1;
      good_q  <= MuBi4False;
    end else begin
      state_q <= state_d;
      // Counter holds at the last word
      if ((state_q == Checking) && (cnt_q != LastCnt)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      match_q <= match_d;
      good_q  <= good_d;
    end
  end

  // Control flow and counter consistency
  assign start_alert    = start_i && (state_q != Waiting);
  assign wait_cnt_alert = (state_q == Waiting) && (cnt_q != '0);
  assign done_cnt_alert = (state_q == Done) && (cnt_q != LastCnt);

  assign done_o  = (state_q == Done);
  assign good_o  = good_q;
  assign alert_o = fsm_alert | start_alert | wait_cnt_alert | done_cnt_alert;

endmodule

// ==== hdl/rom_check_digest_store.sv ====
`timescale 1ns/1ps
// Digest store folding ROM data words into lanes and holding the expected digest words
module rom_check_digest_store import rom_check_pkg::*; #(
  parameter int NumWords = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  rom_word_t              word_i,
  input  logic                   busy_i,
  output logic [NumWords*32-1:0] digest_o,
  output logic [NumWords*32-1:0] exp_digest_o,
  output logic                   full_o
);

  // Word 0 sits in the low bits of both arrays
  logic [NumWords-1:0][31:0] digest_q;
  logic [NumWords-1:0][31:0] exp_q;
  logic                      busy_q;
  logic                      full_q;
  rom_word_data_t            lane_word;
  rom_word_data_t            folded;
  logic                      data_we;
  logic                      exp_we;

  // Split by region
  assign data_we = word_i.valid && !word_i.is_exp;
  assign exp_we  = word_i.valid && word_i.is_exp;

  // Current value of the addressed lane
  assign lane_word = digest_q[word_i.lane];

  // Rotate left then mix in the new data
  assign folded = {lane_word[31-DigestRot:0], lane_word[31:32-DigestRot]} ^ word_i.data;

  // Digest lanes start from zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (data_we) begin
      digest_q[word_i.lane] <= folded;
    end
  end

  // Expected words land in their slot
  always_ff @(posedge clk_i) begin
    if (exp_we) begin
      exp_q[word_i.lane] <= word_i.data;
    end
  end

  // Falling edge of reader busy marks the last absorption
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      busy_q <= busy_i;
      full_q <= busy_q && !busy_i;
    end
  end

  assign digest_o     = digest_q;
  assign exp_digest_o = exp_q;
  assign full_o       = full_q;

endmodule

// ==== hdl/rom_check_pkg.sv ====
// ROM integrity checker shared widths, bus structs, multi-bit booleans and digest constant
package rom_check_pkg;

  // ROM address width, bounds the ROM to 4096 words
  parameter int unsigned RomAddrW = 12;

  // Rotate-left amount of the digest fold
  parameter int unsigned DigestRot = 5;

  typedef logic [31:0] rom_word_data_t;

  // Request from the reader to the external ROM
  typedef struct packed {
    logic                req;
    logic [RomAddrW-1:0] addr;
  } rom_req_t;

  // ROM response, one cycle after each request
  typedef struct packed {
    logic           valid;
    rom_word_data_t rdata;
  } rom_rsp_t;

  // Tagged word from reader to digest store
  typedef struct packed {
    logic           valid;
    // Set for words of the stored expected digest
    logic           is_exp;
    // Digest word index
    logic [3:0]     lane;
    rom_word_data_t data;
  } rom_word_t;

  // Multi-bit boolean
  typedef logic [3:0] mubi4_t;

  parameter mubi4_t MuBi4True  = 4'h6;
  parameter mubi4_t MuBi4False = 4'h9;

endpackage

// ==== hdl/rom_check_reader.sv ====
`timescale 1ns/1ps
// ROM reader that walks every address once and tags each returned word with region and lane
module rom_check_reader import rom_check_pkg::*; #(
  parameter int NumWords = 4,
  parameter int RomDepth = 64
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  output rom_req_t  rom_req_o,
  input  rom_rsp_t  rom_rsp_i,
  output rom_word_t word_o,
  output logic      busy_o,
  output logic      reader_alert_o
);

  localparam logic [RomAddrW-1:0] LastAddr = RomAddrW'(RomDepth - 1);
  // First address of the expected digest region
  localparam logic [RomAddrW-1:0] ExpBase  = RomAddrW'(RomDepth - NumWords);
  localparam logic [3:0]          LastLane = 4'(NumWords - 1);

  logic                reading_q;
  logic                rsp_pend_q;
  logic                alert_q;
  logic [RomAddrW-1:0] addr_q;
  logic [RomAddrW-1:0] rsp_addr_q;
  logic [RomAddrW-1:0] exp_offset;
  logic [3:0]          lane_q;
  logic                start_ok;
  logic                rsp_fire;
  logic                rsp_is_exp;
  logic                word_valid_q;
  logic                word_is_exp_q;
  logic [3:0]          word_lane_q;
  rom_word_data_t      word_data_q;

  // Start only honoured when idle
  assign start_ok   = start_i && !busy_o;
  assign rsp_fire   = rom_rsp_i.valid && rsp_pend_q;
  // Region and lane of the word coming back
  assign rsp_is_exp = (rsp_addr_q >= ExpBase);
  assign exp_offset = rsp_addr_q - ExpBase;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reading_q    <= 1'b0;
      addr_q       <= '0;
      rsp_pend_q   <= 1'b0;
      lane_q       <= '0;
      word_valid_q <= 1'b0;
      alert_q      <= 1'b0;
    end else begin
      if (start_ok) begin
        reading_q <= 1'b1;
        addr_q    <= '0;
      end else if (reading_q) begin
        // One request per cycle, stop after the last address
        if (addr_q == LastAddr) begin
          reading_q <= 1'b0;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
      // Response due one cycle after each request
      rsp_pend_q <= reading_q;
      if (start_ok) begin
        lane_q <= '0;
      end else if (rsp_fire && !rsp_is_exp) begin
        lane_q <= (lane_q == LastLane) ? 4'd0 : lane_q + 4'd1;
      end
      word_valid_q <= rsp_fire;
      // Sticky misuse flag
      if (start_i && busy_o) begin
        alert_q <= 1'b1;
      end
    end
  end

  // Address record and word payload
  always_ff @(posedge clk_i) begin
    if (reading_q) begin
      rsp_addr_q <= addr_q;
    end
    if (rsp_fire) begin
      word_is_exp_q <= rsp_is_exp;
      word_lane_q   <= rsp_is_exp ? exp_offset[3:0] : lane_q;
      word_data_q   <= rom_rsp_i.rdata;
    end
  end

  assign rom_req_o      = '{req: reading_q, addr: addr_q};
  assign word_o         = '{valid: word_valid_q, is_exp: word_is_exp_q,
                            lane: word_lane_q, data: word_data_q};
  // High until the final word has left
  assign busy_o         = reading_q | rsp_pend_q | word_valid_q;
  assign reader_alert_o = alert_q;

endmodule

// ==== hdl/rom_check_top.sv ====
`timescale 1ns/1ps
// ROM integrity checker top joining reader, digest store and comparator
module rom_check_top import rom_check_pkg::*; #(
  parameter int NumWords = 4,
  parameter int RomDepth = 64
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  output rom_req_t rom_req_o,
  input  rom_rsp_t rom_rsp_i,
  output logic     done_o,
  output mubi4_t   good_o,
  output logic     alert_o
);

  rom_word_t              word;
  logic                   reader_busy;
  logic                   reader_alert;
  logic                   store_full;
  logic                   compare_alert;
  logic [NumWords*32-1:0] digest;
  logic [NumWords*32-1:0] exp_digest;

  // Walks the ROM
  rom_check_reader #(
    .NumWords (NumWords),
    .RomDepth (RomDepth)
  ) u_reader (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .rom_req_o      (rom_req_o),
    .rom_rsp_i      (rom_rsp_i),
    .word_o         (word),
    .busy_o         (reader_busy),
    .reader_alert_o (reader_alert)
  );

  // Folds data, keeps expected words
  rom_check_digest_store #(
    .NumWords (NumWords)
  ) u_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_i       (word),
    .busy_i       (reader_busy),
    .digest_o     (digest),
    .exp_digest_o (exp_digest),
    .full_o       (store_full)
  );

  // Store full kicks off the comparison
  rom_check_compare #(
    .NumWords (NumWords)
  ) u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (store_full),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .done_o       (done_o),
    .good_o       (good_o),
    .alert_o      (compare_alert)
  );

  // Start while busy never reaches the comparator
  assign alert_o = compare_alert | reader_alert;

endmodule

// ==== rom_check.f ====
+incdir+test
hdl/rom_check_pkg.sv
hdl/rom_check_reader.sv
hdl/rom_check_digest_store.sv
hdl/rom_check_compare.sv
hdl/rom_check_top.sv
test/tb_rom_check.sv

// ==== test/tb_rom_check_ref.svh ====
// ROM image model with random fill and the reference rotate-xor digest of the data region
`ifndef TB_ROM_CHECK_REF_SVH
`define TB_ROM_CHECK_REF_SVH

// Data region first, expected digest in the top NumWords words
logic [31:0] rom_image [RomDepth];
integer      seed;

// Whole image from the running seed
task automatic fill_image();
  for (int i = 0; i < RomDepth; i++) begin
    rom_image[i] = $random(seed);
  end
endtask

// Each data word folds into lane i mod NumWords
function automatic logic [NumWords*32-1:0] ref_digest();
  logic [NumWords-1:0][31:0] lanes;
  int                        lane;
  lanes = '0;
  for (int i = 0; i < RomDepth - NumWords; i++) begin
    lane        = i % NumWords;
    // Rotate left, then xor in the data
    lanes[lane] = ((lanes[lane] << DigestRot) | (lanes[lane] >> (32 - DigestRot)))
                  ^ rom_image[i];
  end
  return lanes;
endfunction

// Expected region matching the data
task automatic write_expected();
  logic [NumWords-1:0][31:0] dig;
  dig = ref_digest();
  for (int k = 0; k < NumWords; k++) begin
    rom_image[RomDepth - NumWords + k] = dig[k];
  end
endtask

`endif

// ==== test/tb_rom_check.sv ====
`timescale 1ns/1ps
// Testbench for the ROM integrity checker with a ROM responder and reference digest
module tb_rom_check import rom_check_pkg::*;;

  localparam int NumWords    = 4;
  localparam int RomDepth    = 64;
  localparam int DoneTimeout = 4 * RomDepth;

  logic     clk_i     = 1'b0;
  logic     rst_ni    = 1'b0;
  logic     start_i   = 1'b0;
  rom_rsp_t rom_rsp_i = '0;
  rom_req_t rom_req_o;
  logic     done_o;
  mubi4_t   good_o;
  logic     alert_o;
  int       req_count = 0;

  `include "tb_rom_check_ref.svh"

  rom_check_top #(
    .NumWords (NumWords),
    .RomDepth (RomDepth)
  ) uut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (start_i),
    .rom_req_o (rom_req_o),
    .rom_rsp_i (rom_rsp_i),
    .done_o    (done_o),
    .good_o    (good_o),
    .alert_o   (alert_o)
  );

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
      abort_run("Mismatch on a DUT output");
    end
  endtask

  // Answers each request one cycle later and checks the address order
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rom_rsp_i <= '0;
      req_count <= 0;
    end else if (rom_req_o.req) begin
      check_value("rom_req_o.addr", 32'(rom_req_o.addr), 32'(req_count));
      rom_rsp_i <= '{valid: 1'b1, rdata: rom_image[rom_req_o.addr]};
      req_count <= req_count + 1;
    end else begin
      rom_rsp_i <= '0;
    end
  end

  // True only when every expected word equals the reference digest
  function automatic mubi4_t expected_good();
    logic [NumWords-1:0][31:0] dig;
    logic                      match;
    dig   = ref_digest();
    match = 1'b1;
    for (int k = 0; k < NumWords; k++) begin
      if (rom_image[RomDepth - NumWords + k] != dig[k]) begin
        match = 1'b0;
      end
    end
    return match ? MuBi4True : MuBi4False;
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni  <= 1'b0;
    start_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while ((done_o !== 1'b1) && (cycles < DoneTimeout)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_o !== 1'b1) begin
      abort_run("Timeout: done_o did not rise after the ROM was read");
    end
  endtask

  // One run from reset to verdict with an optional second start mid-read
  task automatic run_scenario(input string name, input logic start_twice);
    mubi4_t exp_good;
    exp_good = expected_good();
    $display("Scenario: %s", name);
    apply_reset();
    @(negedge clk_i);
    check_value("done_o", 32'(done_o), 32'd0);
    check_value("good_o", 32'(good_o), 32'(MuBi4False));
    check_value("alert_o", 32'(alert_o), 32'd0);
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    if (start_twice) begin
      repeat (8) @(negedge clk_i);
      // Reader still busy here
      check_value("rom_req_o.req", 32'(rom_req_o.req), 32'd1);
      @(posedge clk_i);
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
    end
    wait_for_done();
    check_value("good_o", 32'(good_o), 32'(exp_good));
    check_value("alert_o", 32'(alert_o), 32'(start_twice));
    check_value("request count", 32'(req_count), 32'(RomDepth));
  endtask

  initial begin
    seed = 32'hedfe;
    fill_image();
    write_expected();
    run_scenario("good image", 1'b0);
    // Single bit flip in the data region
    fill_image();
    write_expected();
    rom_image[17][9] = ~rom_image[17][9];
    run_scenario("corrupt data word", 1'b0);
    // Each expected lane altered alone
    for (int k = 0; k < NumWords; k++) begin
      fill_image();
      write_expected();
      rom_image[RomDepth - NumWords + k] ^= 32'h1 << (k * 7);
      run_scenario($sformatf("corrupt expected word %0d", k), 1'b0);
    end
    fill_image();
    write_expected();
    run_scenario("second start while reading", 1'b1);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
